//--- vlog.f
logic/fetchCfgPkg.sv
logic/isaPkg.sv
logic/pcGen.sv
logic/instrMem.sv
logic/fetchQueue.sv
logic/decodeStage.sv
logic/fetchTop.sv
tb/tbClock.sv
tb/fetchTb.sv

//--- run.sh
#!/usr/bin/env bash
# build the fetch front end testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

buildLog=build.log
simLog=sim.log

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f vlog.f --top-module fetchTb -o fetchSim \
    > "$buildLog" 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see $buildLog"
    exit 1
fi

./obj_dir/fetchSim > "$simLog" 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see $simLog"
    exit 1
fi

if grep -q "Verification failed" "$simLog"; then
    echo "simulation reported a failure, see $simLog"
    exit 1
fi

echo "simulation finished, no failure in $simLog"
exit 0

//--- tb/fetchTb.sv
`timescale 1ns/1ps
`default_nettype none

module fetchTb
    import fetchCfgPkg::*;
    import isaPkg::*;
();

    localparam int memDepth   = memDepthDefault;
    localparam int queueDepth = queueDepthDefault;
    localparam int waitLimit  = 200; // cycles before a wait gives up

    // expected fields of one decoded word
    typedef struct packed
    {
        instrClassT  cls;
        logic [6:0]  opcode;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;
    } refFieldsT;

    logic                 clk;
    logic                 nrst;
    logic                 redirectValid;
    logic [addrWidth-1:0] redirectTarget;
    logic                 debugLoad;
    logic [addrWidth-1:0] debugAddr;
    logic [dataWidth-1:0] debugInstr;
    logic                 decReady;
    logic                 decValid;
    logic [addrWidth-1:0] decPc;
    instrClassT           decClass;
    opcodeT               decOpcode;
    logic [4:0]           decRd;
    logic [4:0]           decRs1;
    logic [4:0]           decRs2;
    logic [dataWidth-1:0] decImm;

    logic [dataWidth-1:0] modelMem [memDepth]; // program as the testbench sees it
    logic [addrWidth-1:0] expPc;               // next pc decode must hand out
    logic [88:0]          outBus;              // all decode outputs side by side
    logic [88:0]          heldBus;
    logic                 holdPending;         // stalled last edge so outputs must not move
    logic                 debugLoadPrev;
    logic                 checkEn;
    int                   xferCount;
    int                   checks;
    int                   errors;
    int                   timeouts;
    int                   seed;

    assign outBus = {decPc, decClass, decOpcode, decRd, decRs1, decRs2, decImm};

    tbClock #(.halfPeriodNs(10)) tbClock_i (.clk(clk));

    fetchTop #(.memDepth(memDepth), .queueDepth(queueDepth)) fetchTop_i (
        .clk(clk), .nrst(nrst),
        .redirectValid(redirectValid), .redirectTarget(redirectTarget),
        .debugLoad(debugLoad), .debugAddr(debugAddr), .debugInstr(debugInstr),
        .decReady(decReady), .decValid(decValid), .decPc(decPc),
        .decClass(decClass), .decOpcode(decOpcode),
        .decRd(decRd), .decRs1(decRs1), .decRs2(decRs2), .decImm(decImm)
    );

    // low bits of v taken as a signed number of the given width
    function automatic logic [31:0] signExtend(input logic [31:0] v, input int bits);
        logic signed [31:0] s;
        s = $signed(v << (32 - bits));
        return s >>> (32 - bits);
    endfunction

    function automatic int wrapIndex(input logic [addrWidth-1:0] a);
        return int'(a % addrWidth'(memDepth)); // memory aliases past its end
    endfunction

    // rv32i field layout per format
    function automatic refFieldsT refDecode(input logic [31:0] w);
        refFieldsT f;
        f        = '0; // missing fields stay zero
        f.opcode = w[6:0];
        case (w[6:0])
            OP:
            begin
                f.cls = RTYPE;
                f.rd  = w[11:7];
                f.rs1 = w[19:15];
                f.rs2 = w[24:20];
            end
            LOAD, OPIMM, JALR:
            begin
                f.cls = ITYPE;
                f.rd  = w[11:7];
                f.rs1 = w[19:15];
                f.imm = signExtend({20'b0, w[31:20]}, 12);
            end
            STORE:
            begin
                f.cls = STYPE;
                f.rs1 = w[19:15];
                f.rs2 = w[24:20];
                f.imm = signExtend({20'b0, w[31:25], w[11:7]}, 12);
            end
            BRANCH:
            begin
                f.cls = BTYPE;
                f.rs1 = w[19:15];
                f.rs2 = w[24:20];
                f.imm = signExtend({19'b0, w[31], w[7], w[30:25], w[11:8], 1'b0}, 13);
            end
            LUI:
            begin
                f.cls = UTYPE;
                f.rd  = w[11:7];
                f.imm = {w[31:12], 12'b0}; // upper immediate needs no extension
            end
            JAL:
            begin
                f.cls = JTYPE;
                f.rd  = w[11:7];
                f.imm = signExtend({11'b0, w[31], w[19:12], w[20], w[30:21], 1'b0}, 21);
            end
            default:
                f.cls = ILLEGAL;
        endcase
        return f;
    endfunction

    task automatic flagMismatch(input string what, input logic [31:0] got,
                                input logic [31:0] want);
        errors++;
        $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, want);
    endtask

    // one transfer against the model word at the expected pc
    task automatic checkEntry();
        refFieldsT want;
        want = refDecode(modelMem[wrapIndex(expPc)]);
        checks++;
        if (decPc !== expPc)
            flagMismatch("decPc", decPc, expPc);
        if (decClass !== want.cls)
            flagMismatch("decClass", 32'(decClass), 32'(want.cls));
        if (decOpcode !== want.opcode)
            flagMismatch("decOpcode", 32'(decOpcode), 32'(want.opcode));
        if (decRd !== want.rd)
            flagMismatch("decRd", 32'(decRd), 32'(want.rd));
        if (decRs1 !== want.rs1)
            flagMismatch("decRs1", 32'(decRs1), 32'(want.rs1));
        if (decRs2 !== want.rs2)
            flagMismatch("decRs2", 32'(decRs2), 32'(want.rs2));
        if (decImm !== want.imm)
            flagMismatch("decImm", decImm, want.imm);
    endtask

    // sampled at the rising edge where the handshake happens
    always @(posedge clk)
    begin
        if (!nrst)
        begin
            holdPending   = 1'b0;
            debugLoadPrev = 1'b0;
            expPc         = resetVector;
        end
        else
        begin
            if (checkEn && holdPending && !decValid)
            begin
                errors++;
                $display("decValid dropped at %0t while the entry was not taken", $time);
            end
            else if (checkEn && holdPending && outBus !== heldBus)
            begin
                errors++;
                $display("decode outputs changed at %0t while decReady was low", $time);
            end
            if (decValid && decReady)
            begin
                if (checkEn)
                    checkEntry();
                xferCount++;
                expPc = expPc + 1'b1; // stream is word sequential
            end
            holdPending = decValid && !decReady;
            heldBus     = outBus;
            if (redirectValid)
            begin
                expPc       = redirectTarget; // older pcs are gone after this edge
                holdPending = 1'b0;
            end
            else if (debugLoadPrev && !debugLoad)
            begin
                expPc       = resetVector; // program restarts once the load ends
                holdPending = 1'b0;
            end
            debugLoadPrev = debugLoad;
        end
    end

    task automatic finishRun();
        $display("checked %0d entries, %0d errors, %0d timeouts", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    endtask

    task automatic waitTransfers(input int n, input string phase);
        int target;
        int cycles;
        target = xferCount + n;
        cycles = 0;
        while (xferCount < target && cycles < waitLimit)
        begin
            @(negedge clk);
            cycles++;
        end
        if (xferCount < target)
        begin
            timeouts++;
            $display("timeout: %0d of %0d entries delivered during %s",
                     n - (target - xferCount), n, phase);
        end
    endtask

    task automatic waitDecValid();
        int cycles;
        cycles = 0;
        while (!decValid && cycles < 20)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!decValid)
        begin
            timeouts++;
            $display("timeout: decValid never rose after reset");
        end
    endtask

    // decReady for n cycles either random with 3 in 4 high or held high
    task automatic driveReady(input int n, input bit randomReady);
        int r;
        repeat (n)
        begin
            @(negedge clk);
            r        = $random(seed);
            decReady = randomReady ? (r[1:0] != 2'b00) : 1'b1;
        end
    endtask

    // random legal words where the first nine cover every format and one bad word
    task automatic buildProgram();
        logic [6:0]  legalOps [8];
        logic [6:0]  badOps [4];
        logic [31:0] raw;
        int          pick;
        int          i;
        legalOps = '{LOAD, OPIMM, STORE, OP, BRANCH, JAL, JALR, LUI};
        badOps   = '{7'b0000000, 7'b0001111, 7'b0010111, 7'b1111111};
        for (i = 0; i < memDepth; i++)
        begin
            raw  = $random(seed);
            pick = (i < 9) ? i : int'($unsigned($random(seed)) % 10);
            if (pick < 8)
                modelMem[i] = {raw[31:7], legalOps[pick]};
            else
                modelMem[i] = {raw[31:7], badOps[raw[1:0]]};
        end
    endtask

    task automatic loadProgram();
        int i;
        checkEn = 1'b0; // words fetched before the load are stale
        for (i = 0; i < memDepth; i++)
        begin
            @(negedge clk);
            debugLoad  = 1'b1;
            debugAddr  = addrWidth'(i);
            debugInstr = modelMem[i];
        end
        @(negedge clk);
        debugLoad = 1'b0;
        @(negedge clk);
        checkEn = 1'b1;
    endtask

    task automatic redirectTo(input logic [addrWidth-1:0] target);
        @(negedge clk);
        redirectValid  = 1'b1;
        redirectTarget = target;
        @(negedge clk);
        redirectValid = 1'b0;
    endtask

    initial
    begin
        int delivered;
        seed           = 18340;
        nrst           = 1'b0;
        redirectValid  = 1'b0;
        redirectTarget = '0;
        debugLoad      = 1'b0;
        debugAddr      = '0;
        debugInstr     = '0;
        decReady       = 1'b0;
        checkEn        = 1'b0;
        xferCount      = 0;
        checks         = 0;
        errors         = 0;
        timeouts       = 0;
        buildProgram();

        repeat (4)
        begin
            @(negedge clk);
            if (decValid !== 1'b0)
                flagMismatch("decValid in reset", 32'(decValid), 32'd0);
        end
        nrst = 1'b1;
        // read then push then pop so decode stays empty before the third edge
        repeat (2)
        begin
            @(negedge clk);
            if (decValid !== 1'b0)
                flagMismatch("decValid before first word", 32'(decValid), 32'd0);
        end
        waitDecValid();

        loadProgram();
        decReady = 1'b1;
        waitTransfers(40, "sequential fetch");
        driveReady(200, 1'b1); // back-pressure
        driveReady(1, 1'b0);
        waitTransfers(5, "random back-pressure");

        redirectTo(32'd250); // runs across the end of memory
        driveReady(60, 1'b1);
        @(negedge clk);
        decReady = 1'b0;
        redirectTo(32'd17); // decode is holding an entry here
        driveReady(40, 1'b1);
        driveReady(1, 1'b0);
        waitTransfers(10, "redirect");

        // restart at 0 with decode stalled so queue and decode fill up
        @(negedge clk);
        decReady   = 1'b0;
        debugLoad  = 1'b1;
        debugAddr  = '0;
        debugInstr = modelMem[0]; // same word so the model stays valid
        @(negedge clk);
        debugLoad = 1'b0;
        repeat (30) @(negedge clk);
        debugLoad = 1'b1; // halts fetch without a flush
        repeat (2) @(negedge clk);
        delivered = xferCount;
        decReady  = 1'b1;
        repeat (30) @(negedge clk);
        delivered = xferCount - delivered;
        if (delivered != queueDepth + 1)
            flagMismatch("entries after stall", 32'(delivered), 32'(queueDepth + 1));
        debugLoad = 1'b0;
        waitTransfers(20, "restart after halt");
        finishRun();
    end

endmodule

`default_nettype wire

//--- tb/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

// free running clock for the testbench, starts low
module tbClock
#(
    parameter int halfPeriodNs = 10 // 20 ns period
)
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever
            #(halfPeriodNs) clk = ~clk;
    end

endmodule

`default_nettype wire

//--- logic/fetchTop.sv
`timescale 1ns/1ps
`default_nettype none

module fetchTop
    import fetchCfgPkg::*;
    import isaPkg::*;
#(
    parameter int memDepth   = memDepthDefault,
    parameter int queueDepth = queueDepthDefault
)
(
    input  logic                 clk,
    input  logic                 nrst,
    input  logic                 redirectValid,
    input  logic [addrWidth-1:0] redirectTarget,
    input  logic                 debugLoad,
    input  logic [addrWidth-1:0] debugAddr,
    input  logic [dataWidth-1:0] debugInstr,
    input  logic                 decReady,
    output logic                 decValid,
    output logic [addrWidth-1:0] decPc,
    output instrClassT           decClass,
    output opcodeT               decOpcode,
    output logic [4:0]           decRd,
    output logic [4:0]           decRs1,
    output logic [4:0]           decRs2,
    output logic [dataWidth-1:0] decImm
);

    logic [addrWidth-1:0] memAddr;
    logic                 memRead;
    logic [dataWidth-1:0] memInstr;
    logic                 pushValid;
    logic                 pushReady;
    fetchEntryT           pushData;
    logic                 popValid;
    logic                 popReady;
    fetchEntryT           popData;
    logic                 flush; // redirect or end of debug load

    // producer, owns the pc and the flush
    pcGen #(.addrWidth(addrWidth)) pcGen_i (
        .clk(clk), .nrst(nrst),
        .redirectValid(redirectValid), .redirectTarget(redirectTarget),
        .debugLoad(debugLoad), .pushReady(pushReady), .memInstr(memInstr),
        .memAddr(memAddr), .memRead(memRead),
        .pushValid(pushValid), .pushData(pushData), .flush(flush)
    );

    instrMem #(.memDepth(memDepth), .addrWidth(addrWidth), .dataWidth(dataWidth)) instrMem_i (
        .clk(clk), .memAddr(memAddr), .memRead(memRead),
        .debugLoad(debugLoad), .debugAddr(debugAddr), .debugInstr(debugInstr),
        .memInstr(memInstr)
    );

    // buffer between fetch and decode
    fetchQueue #(.depth(queueDepth), .payloadT(fetchEntryT)) fetchQueue_i (
        .clk(clk), .nrst(nrst), .flush(flush),
        .pushValid(pushValid), .pushData(pushData), .popReady(popReady),
        .pushReady(pushReady), .popValid(popValid), .popData(popData)
    );

    // consumer
    decodeStage decodeStage_i (
        .clk(clk), .nrst(nrst), .flush(flush),
        .popValid(popValid), .popData(popData), .decReady(decReady),
        .popReady(popReady), .decValid(decValid), .decPc(decPc),
        .decClass(decClass), .decOpcode(decOpcode),
        .decRd(decRd), .decRs1(decRs1), .decRs2(decRs2), .decImm(decImm)
    );

endmodule

`default_nettype wire

//--- logic/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage
    import fetchCfgPkg::*;
    import isaPkg::*;
(
    input  logic                 clk,
    input  logic                 nrst,
    input  logic                 flush,
    input  logic                 popValid,
    input  fetchEntryT           popData,
    input  logic                 decReady,
    output logic                 popReady,
    output logic                 decValid,
    output logic [addrWidth-1:0] decPc,
    output instrClassT           decClass,
    output opcodeT               decOpcode,
    output logic [4:0]           decRd,
    output logic [4:0]           decRs1,
    output logic [4:0]           decRs2,
    output logic [dataWidth-1:0] decImm
);

    logic [dataWidth-1:0] instr;
    opcodeT               opcode;
    instrClassT           instrClass;
    logic [4:0]           rd;
    logic [4:0]           rs1;
    logic [4:0]           rs2;
    logic [dataWidth-1:0] imm;
    logic                 accept;

    assign instr  = popData.instr;
    assign opcode = opcodeT'(instr[6:0]); // raw bits, may be outside the enum

    // slot frees when empty or when its entry leaves this cycle
    assign popReady = !decValid || decReady;
    assign accept   = popValid && popReady;

    always_comb
    begin
        case (opcode)
            OP:                instrClass = RTYPE;
            LOAD, OPIMM, JALR: instrClass = ITYPE;
            STORE:             instrClass = STYPE;
            BRANCH:            instrClass = BTYPE;
            LUI:               instrClass = UTYPE;
            JAL:               instrClass = JTYPE;
            default:           instrClass = ILLEGAL;
        endcase

        // register fields only where the format has them
        rd  = (instrClass inside {RTYPE, ITYPE, UTYPE, JTYPE}) ? instr[11:7] : 5'd0;
        rs1 = (instrClass inside {RTYPE, ITYPE, STYPE, BTYPE}) ? instr[19:15] : 5'd0;
        rs2 = (instrClass inside {RTYPE, STYPE, BTYPE}) ? instr[24:20] : 5'd0;

        case (instrClass)
            ITYPE:   imm = {{20{instr[31]}}, instr[31:20]};
            STYPE:   imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            BTYPE:   imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                            instr[11:8], 1'b0};
            UTYPE:   imm = {instr[31:12], 12'b0};
            JTYPE:   imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                            instr[30:21], 1'b0};
            default: imm = '0; // RTYPE and ILLEGAL
        endcase
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            decValid <= 1'b0;
        else if (flush)
            decValid <= 1'b0; // queue empties on the same edge
        else if (accept)
            decValid <= 1'b1;
        else if (decReady)
            decValid <= 1'b0; // taken, nothing new behind it
    end

    // outputs hold while decValid waits for decReady
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            decPc     <= popData.pc;
            decClass  <= instrClass;
            decOpcode <= opcode;
            decRd     <= rd;
            decRs1    <= rs1;
            decRs2    <= rs2;
            decImm    <= imm;
        end
    end

endmodule

`default_nettype wire

//--- logic/fetchQueue.sv
`timescale 1ns/1ps
`default_nettype none

module fetchQueue
    import fetchCfgPkg::*;
#(
    parameter int  depth    = queueDepthDefault,
    parameter type payloadT = logic [63:0]
)
(
    input  logic    clk,
    input  logic    nrst,
    input  logic    flush,
    input  logic    pushValid,
    input  payloadT pushData,
    input  logic    popReady,
    output logic    pushReady,
    output logic    popValid,
    output payloadT popData
);

    localparam int ptrWidth = (depth > 1) ? $clog2(depth) : 1;
    localparam int cntWidth = $clog2(depth + 1);

    payloadT             slots [depth];
    logic [ptrWidth-1:0] wrPtr;
    logic [ptrWidth-1:0] rdPtr;
    logic [cntWidth-1:0] count; // entries held
    logic                doPush;
    logic                doPop;

    // wraps at depth, depth need not be a power of two
    function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] p);
        if (p == ptrWidth'(depth - 1))
            return '0;
        return p + 1'b1;
    endfunction

    // one slot kept back for the word already on its way from memory
    assign pushReady = count < cntWidth'(depth - 1);
    assign popValid  = count != '0; // registered count, so no fall-through
    assign popData   = slots[rdPtr];

    assign doPush = pushValid && (count != cntWidth'(depth)); // full never seen
    assign doPop  = popValid && popReady;

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else if (flush)
        begin
            wrPtr <= '0; // flush beats a push or pop on the same edge
            rdPtr <= '0;
            count <= '0;
        end
        else
        begin
            if (doPush)
                wrPtr <= nextPtr(wrPtr);
            if (doPop)
                rdPtr <= nextPtr(rdPtr);
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (doPush)
            slots[wrPtr] <= pushData;
    end

endmodule

`default_nettype wire

//--- logic/instrMem.sv
`timescale 1ns/1ps
`default_nettype none

module instrMem
    import fetchCfgPkg::*;
#(
    parameter int memDepth  = memDepthDefault,
    parameter int addrWidth = fetchCfgPkg::addrWidth,
    parameter int dataWidth = fetchCfgPkg::dataWidth
)
(
    input  logic                 clk,
    input  logic [addrWidth-1:0] memAddr,
    input  logic                 memRead,
    input  logic                 debugLoad,
    input  logic [addrWidth-1:0] debugAddr,
    input  logic [dataWidth-1:0] debugInstr,
    output logic [dataWidth-1:0] memInstr
);

    localparam int idxWidth = (memDepth > 1) ? $clog2(memDepth) : 1;

    logic [dataWidth-1:0] words [memDepth]; // program store
    logic [idxWidth-1:0]  rdIdx;
    logic [idxWidth-1:0]  wrIdx;

    // upper address bits ignored, so addresses wrap around the array
    assign rdIdx = memAddr[idxWidth-1:0];
    assign wrIdx = debugAddr[idxWidth-1:0];

    // debug port loads one word per clock
    always_ff @(posedge clk)
    begin
        if (debugLoad)
            words[wrIdx] <= debugInstr;
    end

    // registered read, word valid the cycle after memRead
    // a same-cycle write is seen only by later reads
    always_ff @(posedge clk)
    begin
        if (memRead)
            memInstr <= words[rdIdx];
    end

endmodule

`default_nettype wire

//--- logic/pcGen.sv
`timescale 1ns/1ps
`default_nettype none

module pcGen
    import fetchCfgPkg::*;
    import isaPkg::*;
#(
    parameter int addrWidth = fetchCfgPkg::addrWidth
)
(
    input  logic                 clk,
    input  logic                 nrst,
    input  logic                 redirectValid,
    input  logic [addrWidth-1:0] redirectTarget,
    input  logic                 debugLoad,
    input  logic                 pushReady,
    input  logic [dataWidth-1:0] memInstr,
    output logic [addrWidth-1:0] memAddr,
    output logic                 memRead,
    output logic                 pushValid,
    output fetchEntryT           pushData,
    output logic                 flush
);

    logic [addrWidth-1:0] pc;         // next address to fetch
    logic [addrWidth-1:0] pcNext;
    logic [addrWidth-1:0] inFlightPc; // address of the outstanding read
    logic                 inFlight;   // a word returns this cycle
    logic                 debugLoadQ;
    logic                 debugEnd;

    assign debugEnd = debugLoadQ && !debugLoad; // falling edge of debugLoad

    // stale entries are dropped on a redirect and when a new program is loaded
    assign flush = redirectValid || debugEnd;

    // queue slack covers the read in flight, so pushReady alone gates the issue
    assign memRead = pushReady && !debugLoad && !flush;
    assign memAddr = pc;

    // the word that returns under a flush belongs to the old stream
    assign pushValid = inFlight && !flush;
    assign pushData  = '{pc: inFlightPc, instr: memInstr};

    always_comb
    begin
        if (redirectValid)
            pcNext = redirectTarget;
        else if (debugEnd)
            pcNext = addrWidth'(resetVector); // restart the freshly loaded program
        else if (memRead)
            pcNext = pc + 1'b1;               // word addressed, no byte offset
        else
            pcNext = pc;
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            pc         <= addrWidth'(resetVector);
            inFlight   <= 1'b0;
            debugLoadQ <= 1'b0;
        end
        else
        begin
            pc         <= pcNext;
            inFlight   <= memRead; // never set on a flush cycle
            debugLoadQ <= debugLoad;
        end
    end

    // pairs the memory output with its address one cycle later
    always_ff @(posedge clk)
    begin
        if (memRead)
            inFlightPc <= pc;
    end

endmodule

`default_nettype wire

//--- logic/isaPkg.sv
`default_nettype none

// instruction set view of the front end: opcodes, formats, queue payload
package isaPkg;

    import fetchCfgPkg::*;

    // major opcodes in bits [6:0], rv32i encodings
    typedef enum logic [6:0]
    {
        LOAD   = 7'b0000011,
        OPIMM  = 7'b0010011,
        STORE  = 7'b0100011,
        OP     = 7'b0110011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111
    } opcodeT;

    // instruction format, picks the field and immediate layout
    typedef enum logic [2:0]
    {
        RTYPE,
        ITYPE,
        STYPE,
        BTYPE,
        UTYPE,
        JTYPE,
        ILLEGAL // anything outside the opcodes above
    } instrClassT;

    // one fetched word together with the address it came from
    typedef struct packed
    {
        logic [addrWidth-1:0] pc;
        logic [dataWidth-1:0] instr;
    } fetchEntryT;

endpackage

`default_nettype wire

//--- logic/fetchCfgPkg.sv
`default_nettype none

// sizing of the fetch path, shared by every block of the front end
package fetchCfgPkg;

    // one word per address, no byte offset in the pc
    localparam int addrWidth = 32;
    localparam int dataWidth = 32; // no compressed instructions

    // memory holds the whole program, power of two so addresses wrap cleanly
    localparam int memDepthDefault = 256;

    // four entries leave three usable plus one slot for the read in flight
    localparam int queueDepthDefault = 4;

    // first fetch after reset or after a debug load
    localparam logic [addrWidth-1:0] resetVector = '0;

endpackage

`default_nettype wire
